// File: common/csr_pkg.sv
//**************************************
// CSR address type, CSR select enum and named addresses
// only the reduced 25-register set is listed here
// vendor addresses follow the machine custom ranges
//**************************************

package csr_pkg;

   parameter int CSR_ADDR_W = 12;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   typedef enum logic [4:0] {
      CSR_NONE,
      CSR_MSTATUS,
      CSR_MISA,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MCOUNTINHIBIT,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_MIP,
      CSR_MCYCLE,
      CSR_MINSTRET,
      CSR_MCYCLEH,
      CSR_MINSTRETH,
      CSR_MVENDORID,
      CSR_MARCHID,
      CSR_MIMPID,
      CSR_MHARTID,
      CSR_DCSR,
      CSR_DPC,
      CSR_MITCNT0,
      CSR_MITB0,
      CSR_MITCTL0,
      CSR_MFDC,
      CSR_MEICPCT
   } csr_sel_e;

   //**************************************
   // standard machine csrs
   //**************************************
   parameter csr_addr_t MSTATUS_ADDR       = 12'h300;
   parameter csr_addr_t MISA_ADDR          = 12'h301;
   parameter csr_addr_t MIE_ADDR           = 12'h304;
   parameter csr_addr_t MTVEC_ADDR         = 12'h305;
   parameter csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
   parameter csr_addr_t MSCRATCH_ADDR      = 12'h340;
   parameter csr_addr_t MEPC_ADDR          = 12'h341;
   parameter csr_addr_t MCAUSE_ADDR        = 12'h342;
   parameter csr_addr_t MTVAL_ADDR         = 12'h343;
   parameter csr_addr_t MIP_ADDR           = 12'h344;
   parameter csr_addr_t MCYCLE_ADDR        = 12'hb00;
   parameter csr_addr_t MINSTRET_ADDR      = 12'hb02;
   parameter csr_addr_t MCYCLEH_ADDR       = 12'hb80;
   parameter csr_addr_t MINSTRETH_ADDR     = 12'hb82;
   // read-only id registers
   parameter csr_addr_t MVENDORID_ADDR     = 12'hf11;
   parameter csr_addr_t MARCHID_ADDR       = 12'hf12;
   parameter csr_addr_t MIMPID_ADDR        = 12'hf13;
   parameter csr_addr_t MHARTID_ADDR       = 12'hf14;
   // debug mode only
   parameter csr_addr_t DCSR_ADDR          = 12'h7b0;
   parameter csr_addr_t DPC_ADDR           = 12'h7b1;

   //**************************************
   // vendor csrs
   //**************************************
   parameter csr_addr_t MITCNT0_ADDR       = 12'h7d2;
   parameter csr_addr_t MITB0_ADDR         = 12'h7d3;
   parameter csr_addr_t MITCTL0_ADDR       = 12'h7d4;
   parameter csr_addr_t MFDC_ADDR          = 12'h7f9;
   parameter csr_addr_t MEICPCT_ADDR       = 12'hbca;

endpackage

// File: common/csr_dec_if.sv
//**************************************
// captured request and decode results
// all signals are combinational between the blocks
//**************************************

interface csr_dec_if;
   import csr_pkg::*;

   // captured request
   csr_addr_t addr;
   logic      wen;
   logic      dbg_halted;

   // decode results
   csr_sel_e  sel;
   logic      legal;
   logic      presync;
   logic      postsync;

   modport ctrl (
      output addr, output wen, output dbg_halted,
      input  sel, input legal, input presync, input postsync
   );

   modport addr_dec (input addr, output sel);

   modport check (
      input  sel, input wen, input dbg_halted,
      output legal, output presync, output postsync
   );

endinterface

// File: csr_decode/csr_addr_decoder.sv
//**************************************
// full 12-bit compare against the named addresses
// any other address selects CSR_NONE
//**************************************

module csr_addr_decoder (
   csr_dec_if.addr_dec dec
);
   import csr_pkg::*;

   always_comb begin
      unique case (dec.addr)
         // trap setup and handling
         MSTATUS_ADDR:       dec.sel = CSR_MSTATUS;
         MISA_ADDR:          dec.sel = CSR_MISA;
         MIE_ADDR:           dec.sel = CSR_MIE;
         MTVEC_ADDR:         dec.sel = CSR_MTVEC;
         MCOUNTINHIBIT_ADDR: dec.sel = CSR_MCOUNTINHIBIT;
         MSCRATCH_ADDR:      dec.sel = CSR_MSCRATCH;
         MEPC_ADDR:          dec.sel = CSR_MEPC;
         MCAUSE_ADDR:        dec.sel = CSR_MCAUSE;
         MTVAL_ADDR:         dec.sel = CSR_MTVAL;
         MIP_ADDR:           dec.sel = CSR_MIP;

         // counters
         MCYCLE_ADDR:        dec.sel = CSR_MCYCLE;
         MINSTRET_ADDR:      dec.sel = CSR_MINSTRET;
         MCYCLEH_ADDR:       dec.sel = CSR_MCYCLEH;
         MINSTRETH_ADDR:     dec.sel = CSR_MINSTRETH;

         // machine information
         MVENDORID_ADDR:     dec.sel = CSR_MVENDORID;
         MARCHID_ADDR:       dec.sel = CSR_MARCHID;
         MIMPID_ADDR:        dec.sel = CSR_MIMPID;
         MHARTID_ADDR:       dec.sel = CSR_MHARTID;

         // debug
         DCSR_ADDR:          dec.sel = CSR_DCSR;
         DPC_ADDR:           dec.sel = CSR_DPC;

         // internal timer 0
         MITCNT0_ADDR:       dec.sel = CSR_MITCNT0;
         MITB0_ADDR:         dec.sel = CSR_MITB0;
         MITCTL0_ADDR:       dec.sel = CSR_MITCTL0;

         // feature disable and pic claim
         MFDC_ADDR:          dec.sel = CSR_MFDC;
         MEICPCT_ADDR:       dec.sel = CSR_MEICPCT;

         default:            dec.sel = CSR_NONE;
      endcase
   end

endmodule

// File: csr_decode/csr_access_check.sv
//**************************************
// legality and sync attributes of a decoded access
// sync attributes ignore legality
//**************************************

module csr_access_check #(
   parameter bit TIMER_LEGAL_EN    = 1'b1,
   parameter bit FAST_INT_REDIRECT = 1'b0
) (
   csr_dec_if.check dec
);
   import csr_pkg::*;

   logic is_valid;
   logic is_id_reg;
   logic is_debug;
   logic is_timer;
   logic is_claim;
   logic presync_class;
   logic postsync_class;
   logic cfg_illegal;

   //**************************************
   // register classes
   //**************************************
   assign is_valid  = (dec.sel != CSR_NONE);
   assign is_id_reg = dec.sel inside {CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};
   assign is_debug  = dec.sel inside {CSR_DCSR, CSR_DPC};
   assign is_timer  = dec.sel inside {CSR_MITCNT0, CSR_MITB0, CSR_MITCTL0};
   assign is_claim  = (dec.sel == CSR_MEICPCT);

   // counter reads must see all older instructions retired
   assign presync_class = dec.sel inside {
      CSR_MFDC, CSR_MCOUNTINHIBIT, CSR_MCYCLE, CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH
   };

   // writes here change fetch or trap state for younger instructions
   assign postsync_class = dec.sel inside {
      CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MFDC, CSR_DPC
   };

   // configuration gating
   assign cfg_illegal = (is_timer & ~TIMER_LEGAL_EN) |
                        (is_claim & FAST_INT_REDIRECT);

   //**************************************
   // results
   //**************************************
   assign dec.legal = is_valid &
                      ~(dec.wen & is_id_reg) &
                      (~is_debug | dec.dbg_halted) &
                      ~cfg_illegal;

   assign dec.presync  = presync_class & ~dec.wen;
   assign dec.postsync = postsync_class;

endmodule

// File: logic/csr_req_ctrl.sv
//**************************************
// four-phase req/ack control, one request in flight
// inputs must be stable while req is high
// ack rises two edges after req is first sampled high
//**************************************

module csr_req_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req,
   input  csr_pkg::csr_addr_t   addr,
   input  logic                 wen,
   input  logic                 dbg_halted,
   output logic                 ack,
   output csr_pkg::csr_sel_e    sel,
   output logic                 legal,
   output logic                 presync,
   output logic                 postsync,
   csr_dec_if.ctrl              dec
);
   import csr_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DECODE,
      ST_ACK
   } ctrl_state_e;

   ctrl_state_e state;
   ctrl_state_e state_nxt;

   csr_addr_t   req_addr_q;
   logic        req_wen_q;
   logic        req_halted_q;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:   if (req) state_nxt = ST_DECODE;
         ST_DECODE: state_nxt = ST_ACK;
         ST_ACK:    if (!req) state_nxt = ST_IDLE;
         default:   state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // request capture
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && req) begin
         req_addr_q   <= addr;
         req_wen_q    <= wen;
         req_halted_q <= dbg_halted;
      end
   end

   assign dec.addr       = req_addr_q;
   assign dec.wen        = req_wen_q;
   assign dec.dbg_halted = req_halted_q;

   //**************************************
   // result registers, held until the next decode
   //**************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel      <= CSR_NONE;
         legal    <= 1'b0;
         presync  <= 1'b0;
         postsync <= 1'b0;
      end else if (state == ST_DECODE) begin
         sel      <= dec.sel;
         legal    <= dec.legal;
         presync  <= dec.presync;
         postsync <= dec.postsync;
      end
   end

   assign ack = (state == ST_ACK);

endmodule

// File: logic/csr_decode_top.sv
//**************************************
// registered csr access decoder
// four-phase req/ack, results valid while ack is high
// timer group legal only with TIMER_LEGAL_EN
//**************************************

module csr_decode_top #(
   parameter bit TIMER_LEGAL_EN    = 1'b1,
   parameter bit FAST_INT_REDIRECT = 1'b0
) (
   input  logic                 clk,
   input  logic                 rst_n,

   // requester side
   input  logic                 req,
   input  csr_pkg::csr_addr_t   addr,
   input  logic                 wen,
   input  logic                 dbg_halted,

   // results
   output logic                 ack,
   output csr_pkg::csr_sel_e    sel,
   output logic                 legal,
   output logic                 presync,
   output logic                 postsync
);

   csr_dec_if u_dec_if ();

   csr_req_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wen        (wen),
      .dbg_halted (dbg_halted),
      .ack        (ack),
      .sel        (sel),
      .legal      (legal),
      .presync    (presync),
      .postsync   (postsync),
      .dec        (u_dec_if)
   );

   // combinational datapath on the captured request
   csr_addr_decoder u_addr_decoder (
      .dec (u_dec_if)
   );

   csr_access_check #(
      .TIMER_LEGAL_EN    (TIMER_LEGAL_EN),
      .FAST_INT_REDIRECT (FAST_INT_REDIRECT)
   ) u_access_check (
      .dec (u_dec_if)
   );

endmodule

// File: sim/tb_clk_gen.sv
//****************************************
// free-running testbench clock
// starts low, first rising edge at PERIOD/2
//****************************************

module tb_clk_gen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD / 2) clk = ~clk;

endmodule

// File: sim/csr_decode_tb.sv
//****************************************
// table-driven testbench for csr_decode_top
// built with TIMER_LEGAL_EN=0, FAST_INT_REDIRECT=1
// inputs change 1 time unit after the rising edge
//****************************************

module csr_decode_tb;
   import csr_pkg::*;

   localparam int ACK_TIMEOUT = 20;
   localparam int NUM_RANDOM  = 24;

   typedef struct packed {
      csr_addr_t addr;
      logic      wen;
      logic      halted;
      csr_sel_e  sel;
      logic      legal;
      logic      presync;
      logic      postsync;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic        req;
   csr_addr_t   addr;
   logic        wen;
   logic        dbg_halted;
   logic        ack;
   csr_sel_e    sel;
   logic        legal;
   logic        presync;
   logic        postsync;

   row_t        rows[$];
   logic [31:0] rng_state;
   int          cur_row;

   tb_clk_gen #(.PERIOD(8)) u_clk_gen (.clk(clk));

   csr_decode_top #(
      .TIMER_LEGAL_EN    (1'b0),
      .FAST_INT_REDIRECT (1'b1)
   ) u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wen        (wen),
      .dbg_halted (dbg_halted),
      .ack        (ack),
      .sel        (sel),
      .legal      (legal),
      .presync    (presync),
      .postsync   (postsync)
   );

   //****************************************
   // helpers
   //****************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_sel(input csr_sel_e got, input csr_sel_e exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED row %0d sel: got %h expected %h", cur_row, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED row %0d %s: got %h expected %h", cur_row, name, got, exp));
      end
   endtask

   task automatic check_results(input row_t r);
      check_sel(sel, r.sel);
      check_flag("legal", legal, r.legal);
      check_flag("presync", presync, r.presync);
      check_flag("postsync", postsync, r.postsync);
   endtask

   task automatic add_row(input csr_addr_t a, input logic w, input logic h,
                          input csr_sel_e s, input logic lg, input logic pre,
                          input logic post);
      row_t r;
      r.addr     = a;
      r.wen      = w;
      r.halted   = h;
      r.sel      = s;
      r.legal    = lg;
      r.presync  = pre;
      r.postsync = post;
      rows.push_back(r);
   endtask

   function automatic logic is_kept_addr(input csr_addr_t a);
      foreach (rows[i]) begin
         if (rows[i].sel != CSR_NONE && rows[i].addr == a) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   // one full four-phase transfer with timing and hold checks
   task automatic run_request(input row_t r);
      int edges;
      int hold;
      @(posedge clk);
      #1;
      check_flag("ack", ack, 1'b0);
      req        = 1'b1;
      addr       = r.addr;
      wen        = r.wen;
      dbg_halted = r.halted;
      edges      = 0;
      while (ack !== 1'b1) begin
         if (edges >= ACK_TIMEOUT) begin
            stop_run($sformatf("timeout: no ack within %0d cycles on row %0d",
                               ACK_TIMEOUT, cur_row));
         end
         @(posedge clk);
         #1;
         edges++;
      end
      if (edges != 2) begin
         stop_run($sformatf("ack rose %0d edges after req on row %0d, expected 2",
                            edges, cur_row));
      end
      check_results(r);
      rng_state = xorshift32(rng_state);
      hold      = int'(rng_state[1:0]);
      repeat (hold) begin
         @(posedge clk);
         #1;
         check_flag("ack", ack, 1'b1);
         check_results(r);
      end
      // the address may change once req is low
      req       = 1'b0;
      rng_state = xorshift32(rng_state);
      addr      = rng_state[CSR_ADDR_W-1:0];
      @(posedge clk);
      #1;
      check_flag("ack", ack, 1'b0);
   endtask

   //****************************************
   // stimulus table
   //****************************************
   task automatic build_table();
      csr_addr_t a;
      // reads of every kept csr, not halted unless debug
      add_row(MSTATUS_ADDR,       1'b0, 1'b0, CSR_MSTATUS,       1'b1, 1'b0, 1'b1);
      add_row(MISA_ADDR,          1'b0, 1'b0, CSR_MISA,          1'b1, 1'b0, 1'b0);
      add_row(MIE_ADDR,           1'b0, 1'b0, CSR_MIE,           1'b1, 1'b0, 1'b0);
      add_row(MTVEC_ADDR,         1'b0, 1'b0, CSR_MTVEC,         1'b1, 1'b0, 1'b1);
      add_row(MCOUNTINHIBIT_ADDR, 1'b0, 1'b0, CSR_MCOUNTINHIBIT, 1'b1, 1'b1, 1'b0);
      add_row(MSCRATCH_ADDR,      1'b0, 1'b0, CSR_MSCRATCH,      1'b1, 1'b0, 1'b0);
      add_row(MEPC_ADDR,          1'b0, 1'b0, CSR_MEPC,          1'b1, 1'b0, 1'b1);
      add_row(MCAUSE_ADDR,        1'b0, 1'b0, CSR_MCAUSE,        1'b1, 1'b0, 1'b0);
      add_row(MTVAL_ADDR,         1'b0, 1'b0, CSR_MTVAL,         1'b1, 1'b0, 1'b0);
      add_row(MIP_ADDR,           1'b0, 1'b0, CSR_MIP,           1'b1, 1'b0, 1'b0);
      add_row(MCYCLE_ADDR,        1'b0, 1'b0, CSR_MCYCLE,        1'b1, 1'b1, 1'b0);
      add_row(MINSTRET_ADDR,      1'b0, 1'b0, CSR_MINSTRET,      1'b1, 1'b1, 1'b0);
      add_row(MCYCLEH_ADDR,       1'b0, 1'b0, CSR_MCYCLEH,       1'b1, 1'b1, 1'b0);
      add_row(MINSTRETH_ADDR,     1'b0, 1'b0, CSR_MINSTRETH,     1'b1, 1'b1, 1'b0);
      add_row(MVENDORID_ADDR,     1'b0, 1'b0, CSR_MVENDORID,     1'b1, 1'b0, 1'b0);
      add_row(MARCHID_ADDR,       1'b0, 1'b0, CSR_MARCHID,       1'b1, 1'b0, 1'b0);
      add_row(MIMPID_ADDR,        1'b0, 1'b0, CSR_MIMPID,        1'b1, 1'b0, 1'b0);
      add_row(MHARTID_ADDR,       1'b0, 1'b0, CSR_MHARTID,       1'b1, 1'b0, 1'b0);
      add_row(DCSR_ADDR,          1'b0, 1'b1, CSR_DCSR,          1'b1, 1'b0, 1'b0);
      add_row(DPC_ADDR,           1'b0, 1'b1, CSR_DPC,           1'b1, 1'b0, 1'b1);
      add_row(MITCNT0_ADDR,       1'b0, 1'b0, CSR_MITCNT0,       1'b0, 1'b0, 1'b0);
      add_row(MITB0_ADDR,         1'b0, 1'b0, CSR_MITB0,         1'b0, 1'b0, 1'b0);
      add_row(MITCTL0_ADDR,       1'b0, 1'b0, CSR_MITCTL0,       1'b0, 1'b0, 1'b0);
      add_row(MFDC_ADDR,          1'b0, 1'b0, CSR_MFDC,          1'b1, 1'b1, 1'b1);
      add_row(MEICPCT_ADDR,       1'b0, 1'b0, CSR_MEICPCT,       1'b0, 1'b0, 1'b0);
      // read-only id registers refuse writes
      add_row(MVENDORID_ADDR,     1'b1, 1'b0, CSR_MVENDORID,     1'b0, 1'b0, 1'b0);
      add_row(MARCHID_ADDR,       1'b1, 1'b0, CSR_MARCHID,       1'b0, 1'b0, 1'b0);
      add_row(MIMPID_ADDR,        1'b1, 1'b0, CSR_MIMPID,        1'b0, 1'b0, 1'b0);
      add_row(MHARTID_ADDR,       1'b1, 1'b1, CSR_MHARTID,       1'b0, 1'b0, 1'b0);
      // debug csrs need the halted core
      add_row(DCSR_ADDR,          1'b0, 1'b0, CSR_DCSR,          1'b0, 1'b0, 1'b0);
      add_row(DPC_ADDR,           1'b0, 1'b0, CSR_DPC,           1'b0, 1'b0, 1'b1);
      add_row(DCSR_ADDR,          1'b1, 1'b1, CSR_DCSR,          1'b1, 1'b0, 1'b0);
      add_row(DPC_ADDR,           1'b1, 1'b1, CSR_DPC,           1'b1, 1'b0, 1'b1);
      add_row(DPC_ADDR,           1'b1, 1'b0, CSR_DPC,           1'b0, 1'b0, 1'b1);
      // timer group and claim register are gated off here
      add_row(MITCNT0_ADDR,       1'b1, 1'b1, CSR_MITCNT0,       1'b0, 1'b0, 1'b0);
      add_row(MITB0_ADDR,         1'b1, 1'b0, CSR_MITB0,         1'b0, 1'b0, 1'b0);
      add_row(MITCTL0_ADDR,       1'b1, 1'b1, CSR_MITCTL0,       1'b0, 1'b0, 1'b0);
      add_row(MEICPCT_ADDR,       1'b1, 1'b1, CSR_MEICPCT,       1'b0, 1'b0, 1'b0);
      // writes drop presync but keep postsync
      add_row(MFDC_ADDR,          1'b1, 1'b0, CSR_MFDC,          1'b1, 1'b0, 1'b1);
      add_row(MCOUNTINHIBIT_ADDR, 1'b1, 1'b0, CSR_MCOUNTINHIBIT, 1'b1, 1'b0, 1'b0);
      add_row(MCYCLE_ADDR,        1'b1, 1'b0, CSR_MCYCLE,        1'b1, 1'b0, 1'b0);
      add_row(MINSTRET_ADDR,      1'b1, 1'b1, CSR_MINSTRET,      1'b1, 1'b0, 1'b0);
      add_row(MCYCLEH_ADDR,       1'b1, 1'b0, CSR_MCYCLEH,       1'b1, 1'b0, 1'b0);
      add_row(MINSTRETH_ADDR,     1'b1, 1'b0, CSR_MINSTRETH,     1'b1, 1'b0, 1'b0);
      add_row(MSTATUS_ADDR,       1'b1, 1'b0, CSR_MSTATUS,       1'b1, 1'b0, 1'b1);
      add_row(MTVEC_ADDR,         1'b1, 1'b1, CSR_MTVEC,         1'b1, 1'b0, 1'b1);
      add_row(MEPC_ADDR,          1'b1, 1'b0, CSR_MEPC,          1'b1, 1'b0, 1'b1);
      // unimplemented addresses, some next to real ones
      add_row(12'h000,            1'b0, 1'b0, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'h302,            1'b0, 1'b0, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'h7b2,            1'b1, 1'b1, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'hfff,            1'b0, 1'b1, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'hb01,            1'b1, 1'b0, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'h7d5,            1'b0, 1'b0, CSR_NONE,          1'b0, 1'b0, 1'b0);
      add_row(12'hbcb,            1'b1, 1'b1, CSR_NONE,          1'b0, 1'b0, 1'b0);
      // random addresses outside the kept set
      repeat (NUM_RANDOM) begin
         rng_state = xorshift32(rng_state);
         a         = rng_state[CSR_ADDR_W-1:0];
         if (!is_kept_addr(a)) begin
            add_row(a, rng_state[20], rng_state[21], CSR_NONE, 1'b0, 1'b0, 1'b0);
         end
      end
   endtask

   //****************************************
   // main sequence
   //****************************************
   initial begin
      rst_n      = 1'b0;
      req        = 1'b0;
      addr       = '0;
      wen        = 1'b0;
      dbg_halted = 1'b0;
      rng_state  = 32'he0cc;
      cur_row    = -1;

      build_table();

      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // reset values, then idle with req low
      repeat (3) begin
         check_flag("ack", ack, 1'b0);
         check_sel(sel, CSR_NONE);
         check_flag("legal", legal, 1'b0);
         check_flag("presync", presync, 1'b0);
         check_flag("postsync", postsync, 1'b0);
         @(posedge clk);
         #1;
      end

      foreach (rows[i]) begin
         cur_row = i;
         run_request(rows[i]);
      end

      $display("%0d requests checked", rows.size());
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: src.f
common/csr_pkg.sv
common/csr_dec_if.sv
csr_decode/csr_addr_decoder.sv
csr_decode/csr_access_check.sv
logic/csr_req_ctrl.sv
logic/csr_decode_top.sv
sim/tb_clk_gen.sv
sim/csr_decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR decoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   -f src.f \
   --top-module csr_decode_tb \
   -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vcsr_decode_tb 2>&1)
sim_status=$?
printf '%s\n' "$out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
